// ==== amo_mem.f ====
+incdir+common
common/mem_bus_pkg.sv
common/amo_pkg.sv
common/mem_if.sv
verilog/word_mem.sv
verilog/mem_arbiter.sv
amo/amo_unit.sv
verilog/amo_mem_top.sv
bench/amo_mem_props.sv
bench/amo_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the Verilator model of amo_mem_tb and run it once
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module amo_mem_tb \
  -f amo_mem.f \
  -o amo_mem_sim

out=$(./obj_dir/amo_mem_sim)
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
  exit 0
fi
exit 1

// ==== bench/amo_mem_tb.sv ====
// Reads only words it has written; random traffic keeps writes, AMOs and reads on separate words
module amo_mem_tb
  import mem_bus_pkg::*;
  import amo_pkg::*;
();

  // Operations per test, times 20 cycles each, bound the run
  localparam int OpsTotal = 1 + 24 + 27 + 26 + 6 + 120;

  logic      rst_ni = 1'b0;
  logic      rst_n_i;
  logic      rd0_req, rd1_req, wr_req, amo_req;
  addr_t     rd0_addr, rd1_addr, wr_addr, amo_addr;
  logic      rd0_gnt, rd1_gnt, wr_gnt, amo_ack;
  logic      rd0_rvalid, rd1_rvalid;
  data_t     rd0_rdata, rd1_rdata, wr_data, amo_operand, amo_result;
  be_t       wr_be;
  amo_op_e   amo_op;
  amo_size_e amo_size;

  integer  seed = 74961;
  int      errors = 0;
  int      tests_run = 0;
  int      tests_failed = 0;
  int      mark;
  data_t   shadow [256];
  logic    resv_valid = 1'b0;
  addr_t   resv_addr;
  amo_op_e ops64 [9] = '{AMO_SWAP, AMO_ADD, AMO_AND, AMO_OR, AMO_XOR,
                         AMO_MAX, AMO_MIN, AMO_MAXU, AMO_MINU};
  amo_op_e ops32 [8] = '{AMO_ADD, AMO_MAX, AMO_MAXU, AMO_MIN, AMO_MINU,
                         AMO_SWAP, AMO_XOR, AMO_AND};

  amo_mem_top dut_i (
    .rst_ni (rst_ni), .rst_n_i (rst_n_i),
    .rd0_req_i (rd0_req), .rd0_addr_i (rd0_addr), .rd0_gnt_o (rd0_gnt),
    .rd0_rvalid_o (rd0_rvalid), .rd0_rdata_o (rd0_rdata),
    .rd1_req_i (rd1_req), .rd1_addr_i (rd1_addr), .rd1_gnt_o (rd1_gnt),
    .rd1_rvalid_o (rd1_rvalid), .rd1_rdata_o (rd1_rdata),
    .wr_req_i (wr_req), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
    .wr_be_i (wr_be), .wr_gnt_o (wr_gnt),
    .amo_req_i (amo_req), .amo_op_i (amo_op), .amo_size_i (amo_size),
    .amo_addr_i (amo_addr), .amo_operand_i (amo_operand),
    .amo_ack_o (amo_ack), .amo_result_o (amo_result)
  );

  always #20 rst_ni = ~rst_ni;

  function automatic data_t rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t be);
    data_t m;
    m = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) m[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return m;
  endfunction

  task automatic check(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("[DONE] %s with %0d errors", name, errors - start_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Port drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_word(input addr_t addr, input data_t data, input be_t be);
    @(posedge rst_ni);
    wr_req  <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    wr_be   <= be;
    @(negedge rst_ni);
    while (!wr_gnt) @(negedge rst_ni);
    // Memory takes the bytes at the edge that ends the grant cycle
    shadow[addr[10:3]] = merge_bytes(shadow[addr[10:3]], data, be);
    @(posedge rst_ni);
    wr_req <= 1'b0;
  endtask

  task automatic read_word(input int port, input addr_t addr, output data_t data);
    @(posedge rst_ni);
    if (port == 0) begin
      rd0_req <= 1'b1;
      rd0_addr <= addr;
    end else begin
      rd1_req <= 1'b1;
      rd1_addr <= addr;
    end
    @(negedge rst_ni);
    while (!(port == 0 ? rd0_gnt : rd1_gnt)) @(negedge rst_ni);
    @(posedge rst_ni);
    if (port == 0) rd0_req <= 1'b0;
    else rd1_req <= 1'b0;
    @(negedge rst_ni);
    if (!(port == 0 ? rd0_rvalid : rd1_rvalid)) begin
      $display("Read port %0d gave no data one cycle after its grant", port);
      errors++;
    end
    data = (port == 0) ? rd0_rdata : rd1_rdata;
  endtask

  // Expected return value and new shadow contents of one AMO
  task automatic amo_expect(input amo_op_e op, input amo_size_e size, input addr_t addr,
                            input data_t operand, output data_t ret);
    logic [31:0] half;
    logic        upper;
    logic        write;
    data_t       old_w, a, b, r;
    old_w = shadow[addr[10:3]];
    upper = addr[2];
    half  = upper ? old_w[63:32] : old_w[31:0];
    if (size == AMO_SIZE_W) begin
      a = {{32{half[31]}}, half};
      b = {{32{operand[31]}}, operand[31:0]};
    end else begin
      a = old_w;
      b = operand;
    end
    ret   = a;
    r     = a;
    write = 1'b1;
    case (op)
      AMO_LR: begin
        write = 1'b0;
        resv_valid = 1'b1;
        resv_addr = addr;
      end
      AMO_SC: begin
        if (resv_valid && resv_addr == addr) begin
          ret = '0;
          r = b;
        end else begin
          ret = 64'd1;
          write = 1'b0;
        end
        resv_valid = 1'b0;
      end
      AMO_SWAP: r = b;
      AMO_ADD:  r = a + b;
      AMO_AND:  r = a & b;
      AMO_OR:   r = a | b;
      AMO_XOR:  r = a ^ b;
      AMO_MAX:  r = ($signed(a) >= $signed(b)) ? a : b;
      AMO_MIN:  r = ($signed(a) <= $signed(b)) ? a : b;
      AMO_MAXU: r = (size == AMO_SIZE_W ? a[31:0] >= b[31:0] : a >= b) ? a : b;
      AMO_MINU: r = (size == AMO_SIZE_W ? a[31:0] <= b[31:0] : a <= b) ? a : b;
      default:  write = 1'b0;
    endcase
    if (write && size == AMO_SIZE_W) begin
      if (upper) shadow[addr[10:3]][63:32] = r[31:0];
      else shadow[addr[10:3]][31:0] = r[31:0];
    end else if (write) begin
      shadow[addr[10:3]] = r;
    end
  endtask

  task automatic do_amo(input string name, input amo_op_e op, input amo_size_e size,
                        input addr_t addr, input data_t operand);
    data_t exp;
    amo_expect(op, size, addr, operand, exp);
    @(posedge rst_ni);
    amo_req     <= 1'b1;
    amo_op      <= op;
    amo_size    <= size;
    amo_addr    <= addr;
    amo_operand <= operand;
    @(negedge rst_ni);
    while (!amo_ack) @(negedge rst_ni);
    check(name, exp, amo_result);
    @(posedge rst_ni);
    amo_req <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic random_traffic();
    fork
      for (int n = 0; n < 24; n++) begin
        logic [31:0] r;
        r = $random(seed);
        write_word(addr_t'((64 + r[2:0]) * 8), rand64(), r[15:8]);
      end
      for (int n = 0; n < 24; n++) begin
        logic [31:0] r;
        r = $random(seed);
        do_amo("random_amo", ops64[r[7:0] % 9], amo_size_e'(r[8]),
               addr_t'((72 + r[10:9]) * 8 + r[11] * 4), rand64());
      end
      for (int n = 0; n < 24; n++) begin
        logic [31:0] r;
        data_t got;
        r = $random(seed);
        read_word(0, addr_t'(r[2:0] * 8), got);
        check("random_read", shadow[r[2:0]], got);
      end
      for (int n = 0; n < 24; n++) begin
        logic [31:0] r;
        data_t got;
        r = $random(seed);
        read_word(1, addr_t'(r[2:0] * 8), got);
        check("random_read", shadow[r[2:0]], got);
      end
    join
  endtask

  initial begin
    data_t got;
    logic [31:0] r;
    rd0_req = 1'b0;
    rd1_req = 1'b0;
    wr_req = 1'b0;
    amo_req = 1'b0;
    rd0_addr = '0;
    rd1_addr = '0;
    wr_addr = '0;
    amo_addr = '0;
    wr_data = '0;
    wr_be = '0;
    amo_operand = '0;
    amo_op = AMO_LR;
    amo_size = AMO_SIZE_D;
    rst_n_i = 1'b0;

    mark = errors;
    repeat (4) begin
      @(negedge rst_ni);
      if (rd0_gnt || rd1_gnt || wr_gnt || rd0_rvalid || rd1_rvalid || amo_ack) begin
        $display("A grant, read return or AMO ack was high during reset");
        errors++;
      end
    end
    @(posedge rst_ni);
    rst_n_i <= 1'b1;
    end_test("reset_outputs", mark);

    mark = errors;
    for (int i = 0; i < 8; i++) begin
      write_word(addr_t'(i * 8), rand64(), 8'hff);
      r = $random(seed);
      write_word(addr_t'(i * 8), rand64(), r[7:0]);
      read_word(i % 2, addr_t'(i * 8), got);
      check("byte_write_read", shadow[i], got);
    end
    end_test("byte_write_read", mark);

    mark = errors;
    for (int k = 0; k < 9; k++) begin
      write_word(addr_t'((16 + k) * 8), rand64(), 8'hff);
      do_amo("amo64_old", ops64[k], AMO_SIZE_D, addr_t'((16 + k) * 8), rand64());
      read_word(k % 2, addr_t'((16 + k) * 8), got);
      check("amo64_new", shadow[16 + k], got);
    end
    end_test("amo64_ops", mark);

    // Positive old halves against negative operands
    mark = errors;
    for (int k = 0; k < 8; k++) begin
      write_word(addr_t'((32 + k) * 8), rand64() & 64'h7fff_ffff_7fff_ffff, 8'hff);
      do_amo("amo32_old", ops32[k], AMO_SIZE_W, addr_t'((32 + k) * 8 + (k % 2) * 4),
             rand64() | 64'h8000_0000);
      read_word(k % 2, addr_t'((32 + k) * 8), got);
      check("amo32_new", shadow[32 + k], got);
    end
    do_amo("amo32_sext", AMO_ADD, AMO_SIZE_W, addr_t'(37 * 8 + 4), 64'd1);
    read_word(0, addr_t'(37 * 8), got);
    check("amo32_sext_new", shadow[37], got);
    end_test("amo32_ops", mark);

    mark = errors;
    write_word(addr_t'(48 * 8), rand64(), 8'hff);
    do_amo("lr", AMO_LR, AMO_SIZE_D, addr_t'(48 * 8), '0);
    do_amo("sc_ok", AMO_SC, AMO_SIZE_D, addr_t'(48 * 8), rand64());
    read_word(0, addr_t'(48 * 8), got);
    check("sc_ok_mem", shadow[48], got);
    do_amo("sc_fail", AMO_SC, AMO_SIZE_D, addr_t'(48 * 8), rand64());
    read_word(1, addr_t'(48 * 8), got);
    check("sc_fail_mem", shadow[48], got);
    end_test("lr_sc", mark);

    mark = errors;
    for (int w = 64; w < 76; w++) write_word(addr_t'(w * 8), rand64(), 8'hff);
    random_traffic();
    for (int w = 64; w < 76; w++) begin
      read_word(w % 2, addr_t'(w * 8), got);
      check("random_final", shadow[w], got);
    end
    end_test("random_traffic", mark);

    repeat (2) @(posedge rst_ni);
    $display("Tests: %0d run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, dut_i.props_i.fail_cnt);
    if (errors == 0 && dut_i.props_i.fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (OpsTotal * 20) @(posedge rst_ni);
    $display("Timeout: the tests did not finish in %0d cycles", OpsTotal * 20);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== bench/amo_mem_props.sv ====
// Grant, read return, AMO lock and reset checks on the top ports; AMO state is probed internally
module amo_mem_props
  import mem_bus_pkg::*;
  import amo_pkg::*;
(
  input logic       rst_ni,
  input logic       rst_n_i,
  input logic       rd0_req_i,
  input logic       rd0_gnt_i,
  input logic       rd0_rvalid_i,
  input logic       rd1_req_i,
  input logic       rd1_gnt_i,
  input logic       rd1_rvalid_i,
  input logic       wr_req_i,
  input logic       wr_gnt_i,
  input logic       amo_req_i,
  input logic       amo_ack_i,
  input amo_state_e amo_state_i,
  input logic       amo_rd_pend_i
);

  int         fail_cnt = 0;
  logic [4:0] rd0_wait_q;
  logic [4:0] rd1_wait_q;
  logic [4:0] wr_wait_q;
  logic [4:0] amo_wait_q;
  logic       other_gnt;
  logic       amo_locked;

  assign other_gnt  = rd0_gnt_i || rd1_gnt_i || wr_gnt_i;
  assign amo_locked = (amo_state_i == AMO_WRITE) || (amo_state_i == AMO_READ && amo_rd_pend_i);

  // Cycles each request has waited so far
  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      rd0_wait_q <= '0;
      rd1_wait_q <= '0;
      wr_wait_q  <= '0;
      amo_wait_q <= '0;
    end else begin
      rd0_wait_q <= (rd0_req_i && !rd0_gnt_i) ? rd0_wait_q + 5'd1 : '0;
      rd1_wait_q <= (rd1_req_i && !rd1_gnt_i) ? rd1_wait_q + 5'd1 : '0;
      wr_wait_q  <= (wr_req_i && !wr_gnt_i) ? wr_wait_q + 5'd1 : '0;
      amo_wait_q <= (amo_req_i && !amo_ack_i) ? amo_wait_q + 5'd1 : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////////////////////

  a_one_gnt: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    $onehot0({rd0_gnt_i, rd1_gnt_i, wr_gnt_i}))
    else begin
      $error("two grants in one cycle");
      fail_cnt++;
    end

  a_rd0_ret: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    rd0_gnt_i |=> rd0_rvalid_i)
    else begin
      $error("rd0 return missing");
      fail_cnt++;
    end

  a_rd1_ret: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    rd1_gnt_i |=> rd1_rvalid_i)
    else begin
      $error("rd1 return missing");
      fail_cnt++;
    end

  a_rd0_spur: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    rd0_rvalid_i |-> $past(rd0_gnt_i))
    else begin
      $error("rd0 return without grant");
      fail_cnt++;
    end

  a_rd1_spur: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    rd1_rvalid_i |-> $past(rd1_gnt_i))
    else begin
      $error("rd1 return without grant");
      fail_cnt++;
    end

  // No other client between the AMO read grant and its write
  a_amo_lock: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    amo_locked |-> !other_gnt)
    else begin
      $error("grant inside AMO lock");
      fail_cnt++;
    end

  a_no_starve: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    rd0_wait_q < 5'd16 && rd1_wait_q < 5'd16 && wr_wait_q < 5'd16 && amo_wait_q < 5'd24)
    else begin
      $error("request starved");
      fail_cnt++;
    end

  a_reset: assert property (@(posedge rst_ni)
    !rst_n_i |=> !rd0_rvalid_i && !rd1_rvalid_i && !amo_ack_i && !other_gnt)
    else begin
      $error("outputs active after reset");
      fail_cnt++;
    end

endmodule

bind amo_mem_top amo_mem_props props_i (
  .rst_ni        (rst_ni),
  .rst_n_i       (rst_n_i),
  .rd0_req_i     (rd0_req_i),
  .rd0_gnt_i     (rd0_gnt_o),
  .rd0_rvalid_i  (rd0_rvalid_o),
  .rd1_req_i     (rd1_req_i),
  .rd1_gnt_i     (rd1_gnt_o),
  .rd1_rvalid_i  (rd1_rvalid_o),
  .wr_req_i      (wr_req_i),
  .wr_gnt_i      (wr_gnt_o),
  .amo_req_i     (amo_req_i),
  .amo_ack_i     (amo_ack_o),
  .amo_state_i   (amo_unit_i.state_q),
  .amo_rd_pend_i (amo_unit_i.rd_pend_q)
);

// ==== verilog/amo_mem_top.sv ====
// Requests are levels held until their grant or ack; reads return exactly one cycle after grant
`include "amo_mem_consts.svh"

module amo_mem_top
  import mem_bus_pkg::*;
  import amo_pkg::*;
(
  input  logic      rst_ni,
  input  logic      rst_n_i,
  input  logic      rd0_req_i,
  input  addr_t     rd0_addr_i,
  output logic      rd0_gnt_o,
  output logic      rd0_rvalid_o,
  output data_t     rd0_rdata_o,
  input  logic      rd1_req_i,
  input  addr_t     rd1_addr_i,
  output logic      rd1_gnt_o,
  output logic      rd1_rvalid_o,
  output data_t     rd1_rdata_o,
  input  logic      wr_req_i,
  input  addr_t     wr_addr_i,
  input  data_t     wr_data_i,
  input  be_t       wr_be_i,
  output logic      wr_gnt_o,
  input  logic      amo_req_i,
  input  amo_op_e   amo_op_i,
  input  amo_size_e amo_size_i,
  input  addr_t     amo_addr_i,
  input  data_t     amo_operand_i,
  output logic      amo_ack_o,
  output data_t     amo_result_o
);

  mem_if bus [`AMO_MEM_CLIENTS] ();

  logic   mem_en;
  logic   mem_we;
  index_t mem_index;
  be_t    mem_be;
  data_t  mem_wdata;
  data_t  mem_rdata;

  // Read port 0
  assign bus[CLIENT_RD0].req   = rd0_req_i;
  assign bus[CLIENT_RD0].we    = 1'b0;
  assign bus[CLIENT_RD0].addr  = rd0_addr_i;
  assign bus[CLIENT_RD0].wdata = '0;
  assign bus[CLIENT_RD0].be    = '0;
  assign bus[CLIENT_RD0].lock  = 1'b0;
  assign rd0_gnt_o             = bus[CLIENT_RD0].gnt;
  assign rd0_rvalid_o          = bus[CLIENT_RD0].rvalid;
  assign rd0_rdata_o           = bus[CLIENT_RD0].rdata;

  // Read port 1
  assign bus[CLIENT_RD1].req   = rd1_req_i;
  assign bus[CLIENT_RD1].we    = 1'b0;
  assign bus[CLIENT_RD1].addr  = rd1_addr_i;
  assign bus[CLIENT_RD1].wdata = '0;
  assign bus[CLIENT_RD1].be    = '0;
  assign bus[CLIENT_RD1].lock  = 1'b0;
  assign rd1_gnt_o             = bus[CLIENT_RD1].gnt;
  assign rd1_rvalid_o          = bus[CLIENT_RD1].rvalid;
  assign rd1_rdata_o           = bus[CLIENT_RD1].rdata;

  // Write port whose grant marks the memory update
  assign bus[CLIENT_WR].req   = wr_req_i;
  assign bus[CLIENT_WR].we    = 1'b1;
  assign bus[CLIENT_WR].addr  = wr_addr_i;
  assign bus[CLIENT_WR].wdata = wr_data_i;
  assign bus[CLIENT_WR].be    = wr_be_i;
  assign bus[CLIENT_WR].lock  = 1'b0;
  assign wr_gnt_o             = bus[CLIENT_WR].gnt;

  amo_unit amo_unit_i (
    .rst_ni    (rst_ni),
    .rst_n_i   (rst_n_i),
    .req_i     (amo_req_i),
    .op_i      (amo_op_i),
    .size_i    (amo_size_i),
    .addr_i    (amo_addr_i),
    .operand_i (amo_operand_i),
    .ack_o     (amo_ack_o),
    .result_o  (amo_result_o),
    .bus       (bus[CLIENT_AMO])
  );

  mem_arbiter mem_arbiter_i (
    .rst_ni      (rst_ni),
    .rst_n_i     (rst_n_i),
    .clients_i   (bus),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_index_o (mem_index),
    .mem_be_o    (mem_be),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  word_mem word_mem_i (
    .rst_ni  (rst_ni),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .index_i (mem_index),
    .be_i    (mem_be),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

// ==== amo/amo_unit.sv ====
// One AMO at a time; op, size, addr and operand must stay stable from req_i until ack_o
`include "amo_mem_consts.svh"

module amo_unit
  import mem_bus_pkg::*;
  import amo_pkg::*;
(
  input  logic      rst_ni,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  amo_op_e   op_i,
  input  amo_size_e size_i,
  input  addr_t     addr_i,
  input  data_t     operand_i,
  output logic      ack_o,
  output data_t     result_o,
  mem_if.client     bus
);

  localparam int unsigned HalfW  = `AMO_MEM_DATA_W / 2;
  localparam int unsigned HalfBe = `AMO_MEM_BE_W / 2;

  amo_state_e       state_q;
  amo_state_e       state_d;
  logic             rd_pend_q;
  reservation_t     resv_q;
  logic [HalfW-1:0] old_half;
  data_t            op_a;
  data_t            op_b;
  data_t            op_a_u;
  data_t            op_b_u;
  data_t            new_val;
  data_t            ret_val;
  data_t            wr_word;
  be_t              wr_be;
  logic             sc_ok;
  logic             do_write;
  data_t            result_q;
  data_t            wdata_q;
  be_t              be_q;

  ////////////////////////////////////////////////////////////////////////////
  // Operands and AMO arithmetic
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_operands
    // Bit 2 of the byte address picks the upper word half
    old_half = addr_i[OffsetW-1] ? bus.rdata[HalfW +: HalfW] : bus.rdata[0 +: HalfW];
    if (size_i == AMO_SIZE_W) begin
      op_a   = {{HalfW{old_half[HalfW-1]}}, old_half};
      op_b   = {{HalfW{operand_i[HalfW-1]}}, operand_i[HalfW-1:0]};
      op_a_u = {{HalfW{1'b0}}, old_half};
      op_b_u = {{HalfW{1'b0}}, operand_i[HalfW-1:0]};
    end else begin
      op_a   = bus.rdata;
      op_b   = operand_i;
      op_a_u = bus.rdata;
      op_b_u = operand_i;
    end
  end

  always_comb begin : p_alu
    sc_ok    = resv_q.valid && (resv_q.addr == addr_i);
    ret_val  = op_a;
    new_val  = op_a;
    do_write = 1'b1;
    case (op_i)
      AMO_LR:   do_write = 1'b0;
      AMO_SC: begin
        new_val  = op_b;
        ret_val  = sc_ok ? '0 : data_t'(1);
        do_write = sc_ok;
      end
      AMO_SWAP: new_val = op_b;
      AMO_ADD:  new_val = op_a + op_b;
      AMO_AND:  new_val = op_a & op_b;
      AMO_OR:   new_val = op_a | op_b;
      AMO_XOR:  new_val = op_a ^ op_b;
      AMO_MAX:  new_val = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
      AMO_MIN:  new_val = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
      AMO_MAXU: new_val = (op_a_u > op_b_u) ? op_a : op_b;
      AMO_MINU: new_val = (op_a_u < op_b_u) ? op_a : op_b;
      default:  do_write = 1'b0;
    endcase

    // Word ops write only their half
    if (size_i == AMO_SIZE_W) begin
      wr_word = {2{new_val[HalfW-1:0]}};
      wr_be   = addr_i[OffsetW-1] ? {{HalfBe{1'b1}}, {HalfBe{1'b0}}}
                                  : {{HalfBe{1'b0}}, {HalfBe{1'b1}}};
    end else begin
      wr_word = new_val;
      wr_be   = '1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_next
    state_d = state_q;
    case (state_q)
      AMO_IDLE:  if (req_i) state_d = AMO_READ;
      AMO_READ:  if (bus.rvalid) state_d = do_write ? AMO_WRITE : AMO_DONE;
      AMO_WRITE: if (bus.gnt) state_d = AMO_DONE;
      default:   state_d = AMO_IDLE;
    endcase
  end

  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      state_q   <= AMO_IDLE;
      rd_pend_q <= 1'b0;
      resv_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == AMO_READ && bus.gnt) begin
        rd_pend_q <= 1'b1;
      end else if (bus.rvalid) begin
        rd_pend_q <= 1'b0;
      end
      // Reservation changes when the old word returns
      if (state_q == AMO_READ && bus.rvalid) begin
        if (op_i == AMO_LR) begin
          resv_q.valid <= 1'b1;
          resv_q.addr  <= addr_i;
        end else if (op_i == AMO_SC) begin
          resv_q.valid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge rst_ni) begin
    if (state_q == AMO_READ && bus.rvalid) begin
      result_q <= ret_val;
      wdata_q  <= wr_word;
      be_q     <= wr_be;
    end
  end

  // The read is issued once and the lock covers read through write
  assign bus.req   = (state_q == AMO_READ && !rd_pend_q) || (state_q == AMO_WRITE);
  assign bus.we    = (state_q == AMO_WRITE);
  assign bus.lock  = (state_q == AMO_READ) || (state_q == AMO_WRITE);
  assign bus.addr  = addr_i;
  assign bus.wdata = wdata_q;
  assign bus.be    = be_q;

  assign ack_o    = (state_q == AMO_DONE);
  assign result_o = result_q;

endmodule

// ==== verilog/mem_arbiter.sv ====
// Combinational grant, one grant per cycle; a held lock after a read shuts out all other clients
`include "amo_mem_consts.svh"

module mem_arbiter
  import mem_bus_pkg::*;
(
  input  logic   rst_ni,
  input  logic   rst_n_i,
  mem_if.arbiter clients_i [`AMO_MEM_CLIENTS],
  output logic   mem_en_o,
  output logic   mem_we_o,
  output index_t mem_index_o,
  output be_t    mem_be_o,
  output data_t  mem_wdata_o,
  input  data_t  mem_rdata_i
);

  localparam int unsigned IdW = $bits(client_e);

  logic [`AMO_MEM_CLIENTS-1:0] req_v;
  logic [`AMO_MEM_CLIENTS-1:0] we_v;
  logic [`AMO_MEM_CLIENTS-1:0] lock_v;
  logic [`AMO_MEM_CLIENTS-1:0] gnt_v;
  logic [`AMO_MEM_CLIENTS-1:0] rvalid_v;
  addr_t                       addr_v  [`AMO_MEM_CLIENTS];
  be_t                         be_v    [`AMO_MEM_CLIENTS];
  data_t                       wdata_v [`AMO_MEM_CLIENTS];

  client_e prio_q;
  client_e win_id;
  client_e lock_id_q;
  client_e rd_id_q;
  logic    gnt_any;
  logic    lock_q;
  logic    locked;
  logic    rd_pend_q;

  // Flatten the interface array into plain vectors
  for (genvar c = 0; c < `AMO_MEM_CLIENTS; c++) begin : g_client
    assign req_v[c]   = clients_i[c].req;
    assign we_v[c]    = clients_i[c].we;
    assign lock_v[c]  = clients_i[c].lock;
    assign addr_v[c]  = clients_i[c].addr;
    assign be_v[c]    = clients_i[c].be;
    assign wdata_v[c] = clients_i[c].wdata;

    assign gnt_v[c]    = gnt_any && (win_id == client_e'(c));
    assign rvalid_v[c] = rd_pend_q && (rd_id_q == client_e'(c));

    assign clients_i[c].gnt    = gnt_v[c];
    assign clients_i[c].rvalid = rvalid_v[c];
    assign clients_i[c].rdata  = rvalid_v[c] ? mem_rdata_i : '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Winner selection
  ////////////////////////////////////////////////////////////////////////////

  // Lock stays in force only while its owner keeps lock high
  assign locked = lock_q && lock_v[lock_id_q];

  always_comb begin : p_pick
    logic [IdW-1:0] idx;
    gnt_any = 1'b0;
    win_id  = prio_q;
    idx     = '0;
    if (locked) begin
      gnt_any = req_v[lock_id_q];
      win_id  = lock_id_q;
    end else begin
      // Scan from the current priority slot, wrapping around
      for (int i = 0; i < `AMO_MEM_CLIENTS; i++) begin
        idx = IdW'(prio_q) + IdW'(i);
        if (!gnt_any && req_v[idx]) begin
          gnt_any = 1'b1;
          win_id  = client_e'(idx);
        end
      end
    end
  end

  assign mem_en_o    = gnt_any;
  assign mem_we_o    = gnt_any && we_v[win_id];
  assign mem_index_o = addr_v[win_id][OffsetW +: IndexW];
  assign mem_be_o    = be_v[win_id];
  assign mem_wdata_o = wdata_v[win_id];

  ////////////////////////////////////////////////////////////////////////////
  // Priority, lock and return bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      prio_q    <= CLIENT_RD0;
      lock_q    <= 1'b0;
      lock_id_q <= CLIENT_RD0;
      rd_pend_q <= 1'b0;
      rd_id_q   <= CLIENT_RD0;
    end else begin
      rd_pend_q <= gnt_any && !we_v[win_id];
      if (gnt_any) begin
        // Winner drops to lowest priority
        prio_q  <= client_e'(IdW'(win_id) + 1'b1);
        rd_id_q <= win_id;
      end
      if (gnt_any && lock_v[win_id] && !we_v[win_id]) begin
        lock_q    <= 1'b1;
        lock_id_q <= win_id;
      end else if (lock_q && !lock_v[lock_id_q]) begin
        lock_q <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/word_mem.sv ====
// Single port, one access per cycle; contents power up unknown and read data holds between reads
`include "amo_mem_consts.svh"

module word_mem
  import mem_bus_pkg::*;
(
  input  logic   rst_ni,
  input  logic   en_i,
  input  logic   we_i,
  input  index_t index_i,
  input  be_t    be_i,
  input  data_t  wdata_i,
  output data_t  rdata_o
);

  data_t mem_q [`AMO_MEM_WORDS];

  // Byte-lane write or registered read of the addressed word
  always_ff @(posedge rst_ni) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < `AMO_MEM_BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[index_i];
      end
    end
  end

endmodule

// ==== common/mem_if.sv ====
// One client's request and return path; addr is a byte address, only its word index is used
interface mem_if
  import mem_bus_pkg::*;
();

  // Request held stable until gnt
  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;
  be_t   be;
  logic  lock;

  // Grant and one-cycle-later read return
  logic  gnt;
  logic  rvalid;
  data_t rdata;

  modport client (
    output req, we, addr, wdata, be, lock,
    input  gnt, rvalid, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata, be, lock,
    output gnt, rvalid, rdata
  );

endinterface

// ==== common/amo_pkg.sv ====
// Atomic operation types; only one reservation exists, so a new LR replaces the old one
package amo_pkg;
  import mem_bus_pkg::*;

  // RISC-V AMO opcodes handled by the sequencer
  typedef enum logic [3:0] {
    AMO_LR   = 4'd0,
    AMO_SC   = 4'd1,
    AMO_SWAP = 4'd2,
    AMO_ADD  = 4'd3,
    AMO_AND  = 4'd4,
    AMO_OR   = 4'd5,
    AMO_XOR  = 4'd6,
    AMO_MAX  = 4'd7,
    AMO_MIN  = 4'd8,
    AMO_MAXU = 4'd9,
    AMO_MINU = 4'd10
  } amo_op_e;

  typedef enum logic {
    AMO_SIZE_W = 1'b0,
    AMO_SIZE_D = 1'b1
  } amo_size_e;

  // Read-modify-write sequencer
  typedef enum logic [1:0] {AMO_IDLE, AMO_READ, AMO_WRITE, AMO_DONE} amo_state_e;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } reservation_t;

endpackage

// ==== common/mem_bus_pkg.sv ====
// Types for the shared word bus; client order sets the round-robin order after reset
`include "amo_mem_consts.svh"

package mem_bus_pkg;

  // Word index and byte offset split of a byte address
  localparam int unsigned IndexW  = $clog2(`AMO_MEM_WORDS);
  localparam int unsigned OffsetW = $clog2(`AMO_MEM_BE_W);

  typedef logic [`AMO_MEM_DATA_W-1:0] data_t;
  typedef logic [`AMO_MEM_BE_W-1:0]   be_t;
  typedef logic [`AMO_MEM_ADDR_W-1:0] addr_t;
  typedef logic [IndexW-1:0]          index_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bus clients
  ////////////////////////////////////////////////////////////////////////////

  // Also the arbiter slot of each client
  typedef enum logic [1:0] {
    CLIENT_RD0 = 2'd0,
    CLIENT_RD1 = 2'd1,
    CLIENT_WR  = 2'd2,
    CLIENT_AMO = 2'd3
  } client_e;

endpackage

// ==== common/amo_mem_consts.svh ====
// Word width, byte lanes and depth are tied together; ADDR_W must cover WORDS * BE_W bytes
`ifndef AMO_MEM_CONSTS_SVH
`define AMO_MEM_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Data path
////////////////////////////////////////////////////////////////////////////

// Memory word width in bits
`define AMO_MEM_DATA_W 64

// One enable per byte lane
`define AMO_MEM_BE_W 8

////////////////////////////////////////////////////////////////////////////
// Storage and clients
////////////////////////////////////////////////////////////////////////////

`define AMO_MEM_WORDS 256

// Byte address covering 256 words of 8 bytes
`define AMO_MEM_ADDR_W 11

`define AMO_MEM_CLIENTS 4

`endif
